//--- soc_ifc_pkg.sv
//########################################
// soc_ifc boot package
// boot fsm states, fuse widths and the
// default sizing constants
//########################################
`default_nettype none

package soc_ifc_pkg;

    // fuse bank geometry
    localparam int unsigned FUSE_ADDR_W = 4;
    localparam int unsigned FUSE_DATA_W = 32;

    // index of one fuse word, 16 words max
    typedef logic [FUSE_ADDR_W-1:0] fuse_addr_t;
    // one fuse word
    typedef logic [FUSE_DATA_W-1:0] fuse_data_t;

    // default fw update reset window, in core clocks
    localparam int unsigned FW_RST_CYCLES_DEF = 10;
    // default number of implemented fuse words
    localparam int unsigned FUSE_WORDS_DEF = 16;

    // boot sequencing states
    typedef enum logic [2:0] {
        boot_idle   = 3'd0,
        boot_fuse   = 3'd1,
        boot_fw_rst = 3'd2,
        boot_wait   = 3'd3,
        boot_done   = 3'd4
    } boot_fsm_state_e;

endpackage

`default_nettype wire

//--- soc_ifc_boot_if.sv
//########################################
// soc_ifc boot status interface
// boot fsm to fuse bank handshake levels
//########################################
`timescale 1ns/10ps
`default_nettype none

interface soc_ifc_boot_if;

    // fuse window open, high during the fuse state
    logic ready_for_fuses;
    // global core reset, active low
    logic uc_rst_b;
    // core reset including fw update, active low
    logic uc_fw_rst_b;
    // one cycle iccm unlock on fw update
    logic iccm_unlock;
    // sticky fuse programming done flag
    logic fuse_done;

    // boot fsm side
    // uc_fw_rst_b is driven through the fsm's own output port
    modport fsm (
        output ready_for_fuses,
        output uc_rst_b,
        output iccm_unlock,
        input  fuse_done
    );

    // fuse bank side
    modport fuse (
        input  ready_for_fuses,
        output fuse_done
    );

endinterface

`default_nettype wire

//--- soc_ifc_in_sync.sv
//########################################
// soc_ifc input synchronizer
// 2ff sync of power-good and fw update
// request, request edge turned into a pulse
//########################################
`timescale 1ns/10ps
`default_nettype none

module soc_ifc_in_sync (
    input  logic clk,
    input  logic cptra_rst_b,
    input  logic pwrgood,
    input  logic fw_update_req,
    output logic pwrgood_sync,
    output logic fw_update_pulse
);

    // power-good sync stages
    logic pwrgood_ff1;
    // request sync stages plus edge history
    logic req_ff1;
    logic req_ff2;
    logic req_ff3;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            pwrgood_ff1     <= 1'b0;
            pwrgood_sync    <= 1'b0;
            req_ff1         <= 1'b0;
            req_ff2         <= 1'b0;
            req_ff3         <= 1'b0;
            fw_update_pulse <= 1'b0;
        end else begin
            // level seen 2 clocks after the input changes
            pwrgood_ff1  <= pwrgood;
            pwrgood_sync <= pwrgood_ff1;
            req_ff1      <= fw_update_req;
            req_ff2      <= req_ff1;
            req_ff3      <= req_ff2;
            // rising edge of the synced request, one clock wide
            fw_update_pulse <= req_ff2 & ~req_ff3;
        end
    end

endmodule

`default_nettype wire

//--- soc_ifc_fuse_bank.sv
//########################################
// soc_ifc fuse bank
// fuse write window, readback, range check
// and sticky done flag that locks the bank
//########################################
`timescale 1ns/10ps
`default_nettype none

module soc_ifc_fuse_bank #(
    parameter int unsigned fuse_words = soc_ifc_pkg::FUSE_WORDS_DEF
) (
    input  logic                    clk,
    input  logic                    cptra_rst_b,
    input  logic                    fuse_wr_en,
    input  soc_ifc_pkg::fuse_addr_t fuse_addr,
    input  soc_ifc_pkg::fuse_data_t fuse_wdata,
    input  logic                    fuse_done_wr,
    input  soc_ifc_pkg::fuse_addr_t fuse_rd_addr,
    output soc_ifc_pkg::fuse_data_t fuse_rdata,
    output logic                    fuse_wr_err,
    soc_ifc_boot_if.fuse            boot
);
    import soc_ifc_pkg::*;

    // fuse word storage
    fuse_data_t fuse_mem [fuse_words];

    logic done_q;
    logic window_open;
    logic wr_addr_ok;
    logic rd_addr_ok;
    logic wr_accept;

    // window is open while the fsm is in fuse and done not yet written
    assign window_open = boot.ready_for_fuses & ~done_q;

    // only the implemented words are addressable
    assign wr_addr_ok = (32'(fuse_addr) < fuse_words);
    assign rd_addr_ok = (32'(fuse_rd_addr) < fuse_words);

    assign wr_accept = fuse_wr_en & window_open & wr_addr_ok;

    // storage write port
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            fuse_mem[fuse_addr] <= fuse_wdata;
        end
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            done_q      <= 1'b0;
            fuse_wr_err <= 1'b0;
        end else begin
            // dropped write, flagged for one clock
            fuse_wr_err <= fuse_wr_en & ~(window_open & wr_addr_ok);
            // done strobe only counts inside the window, then sticks
            if (fuse_done_wr && window_open) begin
                done_q <= 1'b1;
            end
        end
    end

    assign boot.fuse_done = done_q;

    // combinational readback, unimplemented words read as zero
    always_comb begin
        fuse_rdata = '0;
        if (rd_addr_ok) begin
            fuse_rdata = fuse_mem[fuse_rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- soc_ifc_boot_fsm.sv
//########################################
// soc_ifc boot fsm
// sequences fuse window, global reset and
// fw reset release, fw update reset timer
// and iccm unlock pulse
//########################################
`timescale 1ns/10ps
`default_nettype none

module soc_ifc_boot_fsm #(
    parameter int unsigned fw_rst_cycles = soc_ifc_pkg::FW_RST_CYCLES_DEF
) (
    input  logic       clk,
    input  logic       cptra_rst_b,
    input  logic       pwrgood_sync,
    input  logic       fw_update_pulse,
    output logic       uc_fw_rst_b,
    soc_ifc_boot_if.fsm boot
);
    import soc_ifc_pkg::*;

    // timer wide enough to hold fw_rst_cycles itself
    localparam int unsigned wait_w = $clog2(fw_rst_cycles + 1);
    typedef logic [wait_w-1:0] wait_cnt_t;
    localparam wait_cnt_t wait_load_val = wait_cnt_t'(fw_rst_cycles);

    // present and next state
    boot_fsm_state_e state_ps;
    boot_fsm_state_e state_ns;

    // state arcs
    logic arc_idle_fuse;
    logic arc_fuse_done;
    logic arc_done_fw_rst;
    logic arc_wait_done;

    // decoded controls
    logic ready_c;
    logic rst_prop_en;
    logic fw_rel;
    logic iccm_unlock_c;
    logic wait_load;
    logic wait_decr;

    // registered reset chain
    logic rst_prop;
    logic uc_rst_q;
    logic fw_rel_q1;
    logic fw_rel_q2;
    logic iccm_unlock_q;
    wait_cnt_t wait_count;

    // leave idle once power-good is synced in
    assign arc_idle_fuse   = pwrgood_sync;
    // fuse bank reports programming complete
    assign arc_fuse_done   = boot.fuse_done;
    // fw update request from the soc
    assign arc_done_fw_rst = fw_update_pulse;
    // update reset window has run out
    assign arc_wait_done   = (wait_count == '0);

    always_comb begin
        state_ns      = state_ps;
        ready_c       = 1'b0;
        rst_prop_en   = 1'b0;
        fw_rel        = 1'b1;
        iccm_unlock_c = 1'b0;
        wait_load     = 1'b1;
        wait_decr     = 1'b0;
        unique case (state_ps)
            boot_idle: begin
                if (arc_idle_fuse) begin
                    state_ns = boot_fuse;
                end
            end
            boot_fuse: begin
                // fuse window open, core held in reset
                ready_c = 1'b1;
                fw_rel  = 1'b0;
                if (arc_fuse_done) begin
                    state_ns = boot_done;
                end
            end
            boot_fw_rst: begin
                // drop fw reset, unlock iccm, start the timer
                fw_rel        = 1'b0;
                iccm_unlock_c = 1'b1;
                wait_load     = 1'b0;
                wait_decr     = 1'b1;
                state_ns      = boot_wait;
            end
            boot_wait: begin
                fw_rel    = 1'b0;
                wait_load = 1'b0;
                wait_decr = 1'b1;
                if (arc_wait_done) begin
                    state_ns = boot_done;
                end
            end
            boot_done: begin
                // let the global reset release through
                rst_prop_en = 1'b1;
                if (arc_done_fw_rst) begin
                    state_ns = boot_fw_rst;
                end
            end
            default: begin
                state_ns = boot_idle;
            end
        endcase
    end

    // only cptra_rst_b brings the fsm back to idle
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_ps      <= boot_idle;
            rst_prop      <= 1'b0;
            uc_rst_q      <= 1'b0;
            fw_rel_q1     <= 1'b0;
            fw_rel_q2     <= 1'b0;
            uc_fw_rst_b   <= 1'b0;
            iccm_unlock_q <= 1'b0;
            wait_count    <= wait_load_val;
        end else begin
            state_ps <= state_ns;
            // global release sticks once done has been reached
            rst_prop <= rst_prop | rst_prop_en;
            uc_rst_q <= rst_prop;
            // fw release through two flops, the direct term asserts reset fast
            fw_rel_q1   <= fw_rel;
            fw_rel_q2   <= fw_rel_q1;
            uc_fw_rst_b <= uc_rst_q & fw_rel & fw_rel_q2;
            iccm_unlock_q <= iccm_unlock_c;
            if (wait_load) begin
                wait_count <= wait_load_val;
            end else if (wait_decr && (wait_count != '0)) begin
                wait_count <= wait_count - 1'b1;
            end
        end
    end

    assign boot.ready_for_fuses = ready_c;
    assign boot.uc_rst_b        = uc_rst_q;
    assign boot.iccm_unlock     = iccm_unlock_q;

endmodule

`default_nettype wire

//--- soc_ifc_boot_top.sv
//########################################
// soc_ifc boot top
// input sync, boot fsm and fuse bank
//########################################
`timescale 1ns/10ps
`default_nettype none

module soc_ifc_boot_top #(
    parameter int unsigned fw_rst_cycles = soc_ifc_pkg::FW_RST_CYCLES_DEF,
    parameter int unsigned fuse_words    = soc_ifc_pkg::FUSE_WORDS_DEF
) (
    input  logic                    clk,
    input  logic                    cptra_rst_b,
    input  logic                    cptra_pwrgood,
    input  logic                    fw_update_req,
    input  logic                    fuse_wr_en,
    input  soc_ifc_pkg::fuse_addr_t fuse_addr,
    input  soc_ifc_pkg::fuse_data_t fuse_wdata,
    input  logic                    fuse_done_wr,
    input  soc_ifc_pkg::fuse_addr_t fuse_rd_addr,
    output logic                    ready_for_fuses,
    output logic                    cptra_uc_rst_b,
    output logic                    cptra_uc_fw_rst_b,
    output logic                    iccm_unlock,
    output soc_ifc_pkg::fuse_data_t fuse_rdata,
    output logic                    fuse_wr_err,
    output logic                    fuse_done
);

    // synced power-good level and update strobe
    logic pwrgood_sync;
    logic fw_update_pulse;

    // boot status between fsm and fuse bank
    soc_ifc_boot_if boot ();

    soc_ifc_in_sync u_in_sync (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .pwrgood         (cptra_pwrgood),
        .fw_update_req   (fw_update_req),
        .pwrgood_sync    (pwrgood_sync),
        .fw_update_pulse (fw_update_pulse)
    );

    soc_ifc_boot_fsm #(
        .fw_rst_cycles (fw_rst_cycles)
    ) u_boot_fsm (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .pwrgood_sync    (pwrgood_sync),
        .fw_update_pulse (fw_update_pulse),
        .uc_fw_rst_b     (boot.uc_fw_rst_b),
        .boot            (boot.fsm)
    );

    soc_ifc_fuse_bank #(
        .fuse_words (fuse_words)
    ) u_fuse_bank (
        .clk          (clk),
        .cptra_rst_b  (cptra_rst_b),
        .fuse_wr_en   (fuse_wr_en),
        .fuse_addr    (fuse_addr),
        .fuse_wdata   (fuse_wdata),
        .fuse_done_wr (fuse_done_wr),
        .fuse_rd_addr (fuse_rd_addr),
        .fuse_rdata   (fuse_rdata),
        .fuse_wr_err  (fuse_wr_err),
        .boot         (boot.fuse)
    );

    // status out to the soc
    assign ready_for_fuses   = boot.ready_for_fuses;
    assign cptra_uc_rst_b    = boot.uc_rst_b;
    assign cptra_uc_fw_rst_b = boot.uc_fw_rst_b;
    assign iccm_unlock       = boot.iccm_unlock;
    assign fuse_done         = boot.fuse_done;

endmodule

`default_nettype wire

//--- tb_soc_ifc_boot.sv
//########################################
// soc_ifc boot testbench
// golden file driven fuse programming,
// boot release and fw update checks
//########################################
`timescale 1ns/10ps
`default_nettype none

module tb_soc_ifc_boot;
    import soc_ifc_pkg::*;

    logic       clk = 1'b0;
    logic       cptra_rst_b;
    logic       cptra_pwrgood;
    logic       fw_update_req;
    logic       fuse_wr_en;
    fuse_addr_t fuse_addr;
    fuse_data_t fuse_wdata;
    logic       fuse_done_wr;
    fuse_addr_t fuse_rd_addr;
    logic       ready_for_fuses;
    logic       cptra_uc_rst_b;
    logic       cptra_uc_fw_rst_b;
    logic       iccm_unlock;
    fuse_data_t fuse_rdata;
    logic       fuse_wr_err;
    logic       fuse_done;

    // golden records in file order
    string      rec_op[$];
    fuse_addr_t rec_addr[$];
    fuse_data_t rec_data[$];

    // error counts per kind of check
    int value_errs = 0;
    int seq_errs = 0;
    int mon_errs = 0;
    // run limit in clocks from the golden record count
    int cycles = 0;
    int limit = 0;
    // monitor state
    int   iccm_pulses = 0;
    logic pwr_seen = 1'b0;
    logic done_seen = 1'b0;
    logic core_up = 1'b0;

    soc_ifc_boot_top #(
        .fw_rst_cycles (10),
        .fuse_words    (12)
    ) u_dut (
        .clk               (clk),
        .cptra_rst_b       (cptra_rst_b),
        .cptra_pwrgood     (cptra_pwrgood),
        .fw_update_req     (fw_update_req),
        .fuse_wr_en        (fuse_wr_en),
        .fuse_addr         (fuse_addr),
        .fuse_wdata        (fuse_wdata),
        .fuse_done_wr      (fuse_done_wr),
        .fuse_rd_addr      (fuse_rd_addr),
        .ready_for_fuses   (ready_for_fuses),
        .cptra_uc_rst_b    (cptra_uc_rst_b),
        .cptra_uc_fw_rst_b (cptra_uc_fw_rst_b),
        .iccm_unlock       (iccm_unlock),
        .fuse_rdata        (fuse_rdata),
        .fuse_wr_err       (fuse_wr_err),
        .fuse_done         (fuse_done)
    );

    // 40 ns core clock
    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    // reset ordering and sticky flags sampled mid-cycle
    always @(negedge clk) begin
        if (cptra_rst_b) begin
            // nothing moves before power-good
            assert (pwr_seen || !(ready_for_fuses || cptra_uc_rst_b || cptra_uc_fw_rst_b))
            else begin
                mon_errs++;
                $display("error at %0t: boot outputs active before power-good", $time);
            end
            // core held in reset while the fuse window is open
            assert (!ready_for_fuses || !(cptra_uc_rst_b || cptra_uc_fw_rst_b)) else begin
                mon_errs++;
                $display("error at %0t: core reset released in fuse window", $time);
            end
            assert (cptra_uc_rst_b || !cptra_uc_fw_rst_b) else begin
                mon_errs++;
                $display("error at %0t: fw reset high while core reset low", $time);
            end
            assert (!done_seen || fuse_done) else begin
                mon_errs++;
                $display("error at %0t: fuse_done dropped", $time);
            end
            // only cptra_rst_b may pull the core back into reset
            assert (!core_up || cptra_uc_rst_b) else begin
                mon_errs++;
                $display("error at %0t: core reset reasserted", $time);
            end
            done_seen = done_seen | fuse_done;
            core_up   = core_up | cptra_uc_rst_b;
            if (iccm_unlock) begin
                iccm_pulses++;
            end
        end
    end

    task automatic load_golden();
        int         fd;
        string      op;
        string      rest;
        fuse_addr_t a;
        fuse_data_t d;
        fd = $fopen("soc_ifc_boot_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file soc_ifc_boot_golden.txt");
            seq_errs++;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    // skip the rest of a comment line
                    void'($fgets(rest, fd));
                end else if ($fscanf(fd, "%h %h", a, d) == 2) begin
                    rec_op.push_back(op);
                    rec_addr.push_back(a);
                    rec_data.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    // 0 to 3 idle clocks between commands
    task automatic wait_gap();
        int unsigned gap;
        gap = $urandom_range(3, 0);
        repeat (gap) @(posedge clk);
    endtask

    task automatic raise_pwrgood();
        int n;
        @(posedge clk);
        cptra_pwrgood <= 1'b1;
        pwr_seen = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ready_for_fuses && n < 8);
        assert (ready_for_fuses && n <= 4) else begin
            seq_errs++;
            $display("error at %0t: fuse window not open within 4 cycles of power-good",
                     $time);
        end
    endtask

    task automatic write_fuse(input fuse_addr_t a, input fuse_data_t d, input logic exp_err);
        @(posedge clk);
        fuse_wr_en <= 1'b1;
        fuse_addr  <= a;
        fuse_wdata <= d;
        @(posedge clk);
        fuse_wr_en <= 1'b0;
        // error flag is registered and shows the cycle after the write
        @(negedge clk);
        assert (fuse_wr_err == exp_err) else begin
            value_errs++;
            $display("error at %0t: write to %h gave fuse_wr_err %b, expected %b",
                     $time, a, fuse_wr_err, exp_err);
        end
    endtask

    task automatic read_fuse(input fuse_addr_t a, input fuse_data_t exp_data);
        @(posedge clk);
        fuse_rd_addr <= a;
        @(negedge clk);
        assert (fuse_rdata === exp_data) else begin
            value_errs++;
            $display("error at %0t: read of %h gave %h, expected %h",
                     $time, a, fuse_rdata, exp_data);
        end
    endtask

    task automatic strobe_done();
        int n;
        int rst_at;
        int fw_at;
        rst_at = 0;
        fw_at  = 0;
        @(posedge clk);
        fuse_done_wr <= 1'b1;
        @(posedge clk);
        fuse_done_wr <= 1'b0;
        // note the cycle of each reset release
        for (n = 1; n <= 10 && fw_at == 0; n++) begin
            @(negedge clk);
            if (cptra_uc_rst_b && rst_at == 0) begin
                rst_at = n;
            end
            if (cptra_uc_fw_rst_b) begin
                fw_at = n;
            end
        end
        assert (rst_at != 0 && rst_at < fw_at && fw_at <= 6) else begin
            seq_errs++;
            $display("error at %0t: after done core reset rose at %0d, fw reset at %0d",
                     $time, rst_at, fw_at);
        end
        assert (fuse_done && !ready_for_fuses) else begin
            seq_errs++;
            $display("error at %0t: fuse window still open or fuse_done low after done",
                     $time);
        end
    endtask

    task automatic request_update();
        int n;
        int low;
        int pulses_before;
        @(posedge clk);
        pulses_before = iccm_pulses;
        fw_update_req <= 1'b1;
        @(posedge clk);
        fw_update_req <= 1'b0;
        // pulse 3 clocks after the request edge and fw reset low within 2 more
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (cptra_uc_fw_rst_b && n < 8);
        assert (!cptra_uc_fw_rst_b && n <= 5) else begin
            seq_errs++;
            $display("error at %0t: fw reset did not drop within 5 cycles of the request",
                     $time);
        end
        // measure the fw reset window
        low = 0;
        while (!cptra_uc_fw_rst_b && low < 20) begin
            assert (cptra_uc_rst_b) else begin
                seq_errs++;
                $display("error at %0t: core reset dropped during fw update", $time);
            end
            low++;
            @(negedge clk);
        end
        assert (low >= 10 && low <= 14) else begin
            seq_errs++;
            $display("error at %0t: fw reset was low for %0d cycles, expected 10 to 14",
                     $time, low);
        end
        // monitor has counted the last negedge sample by the next rising edge
        @(posedge clk);
        assert (iccm_pulses - pulses_before == 1) else begin
            seq_errs++;
            $display("error at %0t: iccm unlock high for %0d cycles, expected one",
                     $time, iccm_pulses - pulses_before);
        end
    endtask

    task automatic run_record(input string op, input fuse_addr_t a, input fuse_data_t d);
        case (op)
            "pwr":   raise_pwrgood();
            "wr":    write_fuse(a, d, 1'b0);
            "wrerr": write_fuse(a, d, 1'b1);
            "rd":    read_fuse(a, d);
            "done":  strobe_done();
            "upd":   request_update();
            default: begin
                seq_errs++;
                $display("unknown golden record %s", op);
            end
        endcase
    endtask

    initial begin
        cptra_rst_b   = 1'b0;
        cptra_pwrgood = 1'b0;
        fw_update_req = 1'b0;
        fuse_wr_en    = 1'b0;
        fuse_addr     = '0;
        fuse_wdata    = '0;
        fuse_done_wr  = 1'b0;
        fuse_rd_addr  = '0;
        void'($urandom(26384));
        load_golden();
        limit = rec_op.size() * 40 + 200;
        // reset held for 3 clocks with the outputs checked inside it
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!(ready_for_fuses || cptra_uc_rst_b || cptra_uc_fw_rst_b || iccm_unlock
                  || fuse_done || fuse_wr_err)) else begin
            value_errs++;
            $display("error at %0t: boot outputs not low during reset", $time);
        end
        @(posedge clk);
        cptra_rst_b <= 1'b1;
        foreach (rec_op[i]) begin
            wait_gap();
            run_record(rec_op[i], rec_addr[i], rec_data[i]);
        end
        repeat (4) @(negedge clk);
        $display("errors: %0d value, %0d sequence, %0d monitor",
                 value_errs, seq_errs, mon_errs);
        if (value_errs + seq_errs + mon_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- soc_ifc_boot_golden.txt
# op     addr  data      addr and data in hex
# wr = accepted write, wrerr = rejected write, rd = read and compare
# pwr = power-good rise, done = done strobe, upd = update request, addr and data unused
wrerr    1     0badf00d
pwr      0     00000000
wr       0     a5a50001
wr       1     5a5a0002
wr       3     c0de0003
wr       7     12345678
wr       b     deadbeef
wrerr    c     11111111
wrerr    f     22222222
rd       0     a5a50001
rd       1     5a5a0002
rd       3     c0de0003
rd       7     12345678
rd       b     deadbeef
rd       c     00000000
rd       f     00000000
done     0     00000000
wrerr    3     ffffffff
rd       3     c0de0003
upd      0     00000000
upd      0     00000000
rd       b     deadbeef

//--- verilog.f
soc_ifc_pkg.sv
soc_ifc_boot_if.sv
soc_ifc_in_sync.sv
soc_ifc_fuse_bank.sv
soc_ifc_boot_fsm.sv
soc_ifc_boot_top.sv
tb_soc_ifc_boot.sv

//--- Makefile
TOP = tb_soc_ifc_boot

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
